// ==== src/cache_params.svh ====
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Cache geometry
`define CACHE_LINES 32
`define WORDS_PER_LINE 16

// Bus widths
`define ADDR_W 32
`define WORD_W 32

`endif

// ==== src/cache_pkg.sv ====
`include "cache_params.svh"

package cache_pkg;

  // Address split into tag, index, word offset and byte offset
  localparam int INDEX_W  = $clog2(`CACHE_LINES);
  localparam int OFFSET_W = $clog2(`WORDS_PER_LINE);
  localparam int BYTE_W   = $clog2(`WORD_W / 8);
  localparam int TAG_W    = `ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
  localparam int LINE_W   = `WORDS_PER_LINE * `WORD_W;

  typedef logic [`ADDR_W-1:0]         addr_t;
  typedef logic [`WORD_W-1:0]         word_t;
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [INDEX_W-1:0]         index_t;
  typedef logic [OFFSET_W-1:0]        offset_t;
  typedef logic [LINE_W-1:0]          line_t;
  typedef logic [`WORDS_PER_LINE-1:0] word_en_t;

  typedef enum logic [2:0] {IDLE, LOOKUP, ACK, SPILL, REFILL, INSTALL} ctrl_state_t;

endpackage

// ==== src/cache_ifs.sv ====
`timescale 1ns/1ps

// Registered processor request split into address fields
interface req_if import cache_pkg::*; ();
  tag_t    tag;
  index_t  index;
  offset_t offset;
  word_t   wdata;

  modport ctrl (output tag, index, offset, wdata);
  modport user (input tag, index, offset, wdata);
endinterface

// Handshake between controller and line burst engine
interface burst_if import cache_pkg::*; ();
  logic  start;
  // 1 for write back, 0 for refill
  logic  spill;
  logic  done;
  line_t fill_line;

  modport ctrl (output start, spill, input done);
  modport engine (input start, spill, output done, fill_line);
endinterface

// ==== src/tag_store.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module tag_store import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  req_if.user   req,
  input  logic  tag_wr,
  input  logic  dirty_set,
  output logic  hit,
  output logic  victim_dirty,
  output tag_t  victim_tag
);

  tag_t                    tags [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid;
  logic [`CACHE_LINES-1:0] dirty;

  // Status bits per line
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (tag_wr) begin
      // Freshly installed line is clean
      valid[req.index] <= 1'b1;
      dirty[req.index] <= 1'b0;
    end else if (dirty_set) begin
      dirty[req.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_wr) begin
      tags[req.index] <= req.tag;
    end
  end

  // Lookup against the indexed line
  assign hit          = valid[req.index] && (tags[req.index] == req.tag);
  assign victim_dirty = valid[req.index] && dirty[req.index];
  assign victim_tag   = tags[req.index];

endmodule

// ==== src/line_store.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module line_store import cache_pkg::*; (
  input  logic  clk,
  req_if.user   req,
  input  logic  word_wr,
  input  logic  line_wr,
  input  line_t fill_line,
  output word_t rd_word,
  output line_t rd_line
);

  line_t    lines [`CACHE_LINES];
  word_en_t word_en;
  line_t    wr_data;
  logic     wr_en;

  // Whole line on install or single word on write hit
  always_comb begin
    if (line_wr) begin
      word_en = '1;
      wr_data = fill_line;
    end else begin
      word_en = word_en_t'(1) << req.offset;
      wr_data = {`WORDS_PER_LINE{req.wdata}};
    end
  end

  assign wr_en = word_wr || line_wr;

  always_ff @(posedge clk) begin
    for (int w = 0; w < `WORDS_PER_LINE; w++) begin
      if (wr_en && word_en[w]) begin
        lines[req.index][w*`WORD_W +: `WORD_W] <= wr_data[w*`WORD_W +: `WORD_W];
      end
    end
  end

  assign rd_line = lines[req.index];
  assign rd_word = rd_line[req.offset*`WORD_W +: `WORD_W];

endmodule

// ==== src/line_burst.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module line_burst import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  req_if.user   req,
  burst_if.engine burst,
  input  tag_t  victim_tag,
  input  line_t rd_line,
  output logic  mem_cyc,
  output logic  mem_stb,
  output logic  mem_we,
  output addr_t mem_adr,
  output word_t mem_dat_w,
  input  word_t mem_dat_r,
  input  logic  mem_ack
);

  logic    busy;
  logic    done_q;
  logic    last_word;
  offset_t count;
  tag_t    line_tag;
  addr_t   line_base;
  line_t   fill_q;

  // --------------------------------------------------
  // Burst sequencing
  // --------------------------------------------------

  assign last_word = (count == offset_t'(`WORDS_PER_LINE - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy   <= 1'b0;
      mem_we <= 1'b0;
      count  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (burst.start) begin
        busy   <= 1'b1;
        mem_we <= burst.spill;
        count  <= '0;
      end else if (busy && mem_ack) begin
        count <= count + 1'b1;
        if (last_word) begin
          busy   <= 1'b0;
          mem_we <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Cycle and strobe stay up across all 16 words
  assign mem_cyc = busy;
  assign mem_stb = busy;

  // --------------------------------------------------
  // Address and data
  // --------------------------------------------------

  // Old line for write back, requested line for refill
  assign line_tag  = burst.spill ? victim_tag : req.tag;
  assign line_base = {line_tag, req.index, {(OFFSET_W + BYTE_W){1'b0}}};
  assign mem_adr   = line_base + (addr_t'(count) << BYTE_W);
  assign mem_dat_w = rd_line[count*`WORD_W +: `WORD_W];

  // Assemble the refill line word by word
  always_ff @(posedge clk) begin
    if (busy && mem_ack && !mem_we) begin
      fill_q[count*`WORD_W +: `WORD_W] <= mem_dat_r;
    end
  end

  assign burst.fill_line = fill_q;
  assign burst.done      = done_q;

endmodule

// ==== src/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_ctrl import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  cyc,
  input  logic  stb,
  input  logic  we,
  input  addr_t adr,
  input  word_t dat_w,
  output logic  ack,
  req_if.ctrl   req,
  burst_if.ctrl burst,
  input  logic  hit,
  input  logic  victim_dirty,
  output logic  tag_wr,
  output logic  dirty_set,
  output logic  word_wr,
  output logic  line_wr
);

  ctrl_state_t state;
  logic        accept;
  logic        we_q;

  assign accept = (state == IDLE) && cyc && stb;

  // --------------------------------------------------
  // Request capture
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      req.tag    <= adr[`ADDR_W-1 -: TAG_W];
      req.index  <= adr[BYTE_W + OFFSET_W +: INDEX_W];
      req.offset <= adr[BYTE_W +: OFFSET_W];
      req.wdata  <= dat_w;
      we_q       <= we;
    end
  end

  // --------------------------------------------------
  // Miss handling FSM
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      burst.start <= 1'b0;
      burst.spill <= 1'b0;
    end else begin
      burst.start <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) state <= LOOKUP;
        end
        LOOKUP: begin
          if (hit) begin
            state <= ACK;
          end else begin
            // Dirty victim goes back to memory before the refill
            burst.start <= 1'b1;
            burst.spill <= victim_dirty;
            state       <= victim_dirty ? SPILL : REFILL;
          end
        end
        ACK: state <= IDLE;
        SPILL: begin
          if (burst.done) begin
            burst.start <= 1'b1;
            burst.spill <= 1'b0;
            state       <= REFILL;
          end
        end
        REFILL: begin
          if (burst.done) state <= INSTALL;
        end
        // Retry the lookup, which now hits
        INSTALL: state <= LOOKUP;
        default: state <= IDLE;
      endcase
    end
  end

  assign ack       = (state == ACK);
  assign word_wr   = (state == ACK) && we_q;
  assign dirty_set = (state == ACK) && we_q;
  assign tag_wr    = (state == INSTALL);
  assign line_wr   = (state == INSTALL);

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  // Processor side
  input  logic  cyc,
  input  logic  stb,
  input  logic  we,
  input  addr_t adr,
  input  word_t dat_w,
  output word_t dat_r,
  output logic  ack,
  // Memory side
  output logic  mem_cyc,
  output logic  mem_stb,
  output logic  mem_we,
  output addr_t mem_adr,
  output word_t mem_dat_w,
  input  word_t mem_dat_r,
  input  logic  mem_ack
);

  logic  hit;
  logic  victim_dirty;
  logic  tag_wr;
  logic  dirty_set;
  logic  word_wr;
  logic  line_wr;
  tag_t  victim_tag;
  line_t rd_line;

  req_if   req ();
  burst_if burst ();

  cache_ctrl u_ctrl (
    .clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .ack,
    .req (req.ctrl), .burst (burst.ctrl),
    .hit, .victim_dirty, .tag_wr, .dirty_set, .word_wr, .line_wr
  );

  tag_store u_tags (
    .clk, .reset, .req (req.user), .tag_wr, .dirty_set,
    .hit, .victim_dirty, .victim_tag
  );

  line_store u_lines (
    .clk, .req (req.user), .word_wr, .line_wr,
    .fill_line (burst.fill_line), .rd_word (dat_r), .rd_line
  );

  line_burst u_burst (
    .clk, .reset, .req (req.user), .burst (burst.engine), .victim_tag, .rd_line,
    .mem_cyc, .mem_stb, .mem_we, .mem_adr, .mem_dat_w, .mem_dat_r, .mem_ack
  );

endmodule

// ==== test/cache_props.sv ====
`timescale 1ns/1ps

module cache_props import cache_pkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  cyc,
  input logic  stb,
  input logic  ack,
  input logic  mem_cyc,
  input logic  mem_stb,
  input addr_t mem_adr
);

  // Processor side
  ack_needs_req: assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc && stb))
    else $error("ack seen without cyc and stb");
  ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
    else $error("ack high on two cycles in a row");

  // Memory side
  stb_in_cyc: assert property (@(posedge clk) disable iff (reset) mem_stb |-> mem_cyc)
    else $error("mem_stb high outside mem_cyc");
  adr_aligned: assert property (@(posedge clk) disable iff (reset) mem_stb |-> mem_adr[1:0] == 2'b00)
    else $error("mem_adr not word aligned");

endmodule

bind cache_top cache_props props (.clk, .reset, .cyc, .stb, .ack, .mem_cyc, .mem_stb, .mem_adr);

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  logic  clk;
  logic  reset;
  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;
  word_t dat_w;
  word_t dat_r;
  logic  ack;
  logic  mem_cyc;
  logic  mem_stb;
  logic  mem_we;
  addr_t mem_adr;
  word_t mem_dat_w;
  word_t mem_dat_r;
  logic  mem_ack;

  // Memory contents and the value the processor should see
  word_t mem [addr_t];
  word_t cpu_view [addr_t];
  // Expected cache state per index
  logic  m_valid [2**INDEX_W];
  logic  m_dirty [2**INDEX_W];
  tag_t  m_tag [2**INDEX_W];
  byte   op_q [$];
  addr_t adr_q [$];
  word_t dat_q [$];
  addr_t spill_adr_q [$];
  word_t spill_dat_q [$];
  int    words_moved;
  int    mismatches;
  int    failures;
  int    cycles;
  int    limit;
  int    seed;

  cache_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic word_t rule_word(input addr_t a);
    return a ^ 32'h5A5A5A5A;
  endfunction

  function automatic word_t expected_word(input addr_t a);
    if (cpu_view.exists(a)) return cpu_view[a];
    return rule_word(a);
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // --------------------------------------------------
  // Memory model with one ack per strobe
  // --------------------------------------------------
  always @(negedge clk) begin
    if (mem_stb && !mem_ack) begin
      words_moved++;
      if (mem_we) begin
        mem[mem_adr] = mem_dat_w;
        if (spill_adr_q.size() == 0) begin
          $display("Memory write at %0t was not expected", $time);
          failures++;
        end else begin
          check_addr(mem_adr, spill_adr_q.pop_front(), "spill address");
          check_word(mem_dat_w, spill_dat_q.pop_front(), "spill data");
        end
      end else begin
        mem_dat_r = mem.exists(mem_adr) ? mem[mem_adr] : rule_word(mem_adr);
      end
      mem_ack = 1'b1;
    end else begin
      mem_ack = 1'b0;
    end
  end

  task automatic read_golden();
    int    fd;
    int    c;
    int    code;
    addr_t a;
    word_t d;
    fd = $fopen("test/cache_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/cache_golden.txt");
      failures++;
      return;
    end
    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != -1 && c != "\n") c = $fgetc(fd);
      end else if (c == "R" || c == "W") begin
        code = $fscanf(fd, "%h %h", a, d);
        if (code != 2) begin
          $display("Golden file line is malformed");
          failures++;
        end else begin
          op_q.push_back(byte'(c));
          adr_q.push_back(a);
          dat_q.push_back(d);
        end
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic run_op(input byte op, input addr_t a, input word_t d);
    index_t idx;
    tag_t   tg;
    logic   miss;
    logic   spill;
    addr_t  base;
    word_t  got;
    int     gap;
    idx   = a[BYTE_W + OFFSET_W +: INDEX_W];
    tg    = tag_t'(a >> (BYTE_W + OFFSET_W + INDEX_W));
    miss  = !(m_valid[idx] && m_tag[idx] == tg);
    spill = miss && m_valid[idx] && m_dirty[idx];
    // Old line goes back in address order
    if (spill) begin
      base = {m_tag[idx], idx, {(OFFSET_W + BYTE_W){1'b0}}};
      for (int k = 0; k < 2**OFFSET_W; k++) begin
        spill_adr_q.push_back(base + addr_t'(4 * k));
        spill_dat_q.push_back(expected_word(base + addr_t'(4 * k)));
      end
    end
    words_moved = 0;
    @(negedge clk);
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = (op == "W");
    adr   = a;
    dat_w = (op == "W") ? d : '0;
    @(negedge clk);
    while (!ack) @(negedge clk);
    got = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
    if (op == "R") check_word(got, d, "read data");
    else cpu_view[a] = d;
    check_word(word_t'(words_moved), word_t'(miss ? (spill ? 32 : 16) : 0), "memory words");
    m_dirty[idx] = (!miss && m_dirty[idx]) || (op == "W");
    m_valid[idx] = 1'b1;
    m_tag[idx]   = tg;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(negedge clk);
  endtask

  // Run limit from the number of operations
  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run did not finish within %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    seed        = 5;
    mismatches  = 0;
    failures    = 0;
    words_moved = 0;
    reset       = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    mem_ack     = 1'b0;
    mem_dat_r   = '0;
    for (int i = 0; i < 2**INDEX_W; i++) begin
      m_valid[i] = 1'b0;
      m_dirty[i] = 1'b0;
      m_tag[i]   = '0;
    end
    read_golden();
    limit = op_q.size() * 80 + 20;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (ack !== 1'b0 || mem_cyc !== 1'b0 || mem_we !== 1'b0) begin
      $display("Bus outputs are not idle after reset");
      failures++;
    end
    foreach (op_q[i]) run_op(op_q[i], adr_q[i], dat_q[i]);
    @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== test/cache_golden.txt ====
# op address data, hex; W writes data, R expects data
# reads follow address ^ 5A5A5A5A unless written before
R 00001048 5A5A4A12
R 0000107C 5A5A4A26
W 00001050 DEADBEEF
R 00001050 DEADBEEF
R 00001054 5A5A4A0E
R 00003044 5A5A6A1E
R 00001050 DEADBEEF
R 00001040 5A5A4A1A
W 00000200 12345678
R 00000200 12345678
R 00000204 5A5A585E
R 00000A04 5A5A505E
R 00000200 12345678

// ==== cache_top.f ====
+incdir+src
src/cache_pkg.sv
src/cache_ifs.sv
src/tag_store.sv
src/line_store.sv
src/line_burst.sv
src/cache_ctrl.sv
src/cache_top.sv
test/cache_props.sv
test/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f cache_top.f
out=$(./obj_dir/Vcache_tb)
echo "$out"
if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
